/* vlog.f */
+incdir+sim
common/ex_pkg.sv
logic/ex_pipe_reg.sv
ex/ex_alu.sv
ex/ex_next_pc.sv
ex/ex_stage.sv
logic/ex_top.sv
sim/ex_tb.sv

/* Bender.yml */
package:
  name: ex_stage

sources:
  - common/ex_pkg.sv
  - logic/ex_pipe_reg.sv
  - ex/ex_alu.sv
  - ex/ex_next_pc.sv
  - ex/ex_stage.sv
  - logic/ex_top.sv
  - target: test
    include_dirs:
      - sim
    files:
      - sim/ex_tb.sv

/* sim/ex_ref_model.svh */
function automatic logic [xlen-1:0] model_alu(alu_op_t op, logic [xlen-1:0] a,
                                              logic [xlen-1:0] b);
    logic signed [xlen-1:0] sa;
    logic signed [xlen-1:0] sb;
    logic [xlen-1:0]        low_z;
    logic signed [xlen-1:0] low_s;
    logic [xlen-1:0]        w;
    sa    = a;
    sb    = b;
    low_z = {32'b0, a[31:0]};
    low_s = {{32{a[31]}}, a[31:0]};
    w     = '0;
    case (op)
        alu_add:    return a + b;
        alu_sub:    return a - b;
        alu_sll:    return a << b[5:0];
        alu_slt:    return (sa < sb) ? 64'd1 : 64'd0;
        alu_sltu:   return (a < b) ? 64'd1 : 64'd0;
        alu_xor:    return a ^ b;
        alu_srl:    return a >> b[5:0];
        alu_sra:    return sa >>> b[5:0];
        alu_or:     return a | b;
        alu_and:    return a & b;
        alu_pass_b: return b;
        alu_addw:   w = a + b;
        alu_subw:   w = a - b;
        alu_sllw:   w = a << b[4:0];
        alu_srlw:   w = low_z >> b[4:0];
        alu_sraw:   w = low_s >>> b[4:0];
        default:    return '0;
    endcase
    // word forms keep the low half and sign-extend it.
    return {{32{w[31]}}, w[31:0]};
endfunction

function automatic logic model_taken(branch_t br, logic [xlen-1:0] y);
    case (br)
        br_jal:  return 1'b1;
        br_jalr: return 1'b1;
        br_eq:   return y == '0;
        br_ne:   return y != '0;
        br_lt:   return y[0];
        br_ge:   return !y[0];
        default: return 1'b0;
    endcase
endfunction

function automatic ex_result_t model_execute(ex_issue_t i);
    logic [xlen-1:0] imm64;
    logic [xlen-1:0] a;
    logic [xlen-1:0] b;
    logic            taken;
    ex_result_t      r;
    imm64 = {{32{i.imm[31]}}, i.imm};
    a     = (i.src_a == src_a_pc) ? i.pc : i.src1;
    case (i.src_b)
        src_b_rs2:  b = i.src2;
        src_b_four: b = 64'd4;
        src_b_imm:  b = imm64;
        default:    b = i.csr_data;
    endcase
    r        = '0;
    r.result = model_alu(i.alu_op, a, b);
    // a csr op never branches and only flushes to the next instruction.
    taken = !i.csr && model_taken(i.branch, r.result);
    if (!taken) begin
        r.next_pc = i.pc + 64'd4;
    end else if (i.branch == br_jalr) begin
        r.next_pc = (i.src1 + imm64) & ~64'd1;
    end else begin
        r.next_pc = i.pc + imm64;
    end
    r.redirect   = taken || i.csr;
    r.store_data = i.src2;
    r.rd         = i.rd;
    r.csr_addr   = i.csr_addr;
    r.mem_op     = i.mem_op;
    r.mem_rd     = i.mem_rd;
    r.mem_wr     = i.mem_wr;
    r.reg_wr     = i.reg_wr;
    r.csr        = i.csr;
    r.ecall      = i.ecall;
    r.mret       = i.mret;
    return r;
endfunction

/* sim/ex_tb.sv */
`timescale 1ns/1ps

module ex_tb;

    import ex_pkg::*;

    `include "ex_ref_model.svh"

    localparam int n_cycles    = 3000;
    localparam int cycle_limit = 2 * n_cycles + 100;

    logic            clk;
    logic            reset;
    logic            block;
    logic            issue_valid;
    ex_issue_t       issue;
    logic            out_valid;
    ex_result_t      out;
    logic            redirect_valid;
    logic [xlen-1:0] redirect_pc;

    // model pipeline with one entry per register stage.
    logic       m_s1_valid;
    ex_issue_t  m_s1;
    logic       m_s2_valid;
    ex_result_t m_s2;
    logic       took_beat;

    int          errors;
    int          checks;
    int          cycles;
    int          issued;
    int          delivered;

    ex_top uut (
        .clk            (clk),
        .reset          (reset),
        .block          (block),
        .issue_valid    (issue_valid),
        .issue          (issue),
        .out_valid      (out_valid),
        .out            (out),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc)
    );

    always #50 clk = ~clk;

    // ####################
    // model and limits
    // ####################

    always @(posedge clk) begin
        took_beat = !block;
        if (reset) begin
            m_s1_valid = 1'b0;
            m_s2_valid = 1'b0;
        end else if (!block) begin
            m_s2_valid = m_s1_valid;
            m_s2       = model_execute(m_s1);
            m_s1_valid = issue_valid;
            m_s1       = issue;
            if (issue_valid) begin
                issued++;
            end
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > cycle_limit) begin
            $display("timeout: the run did not finish within %0d cycles", cycle_limit);
            $display("Something failed");
            $finish;
        end
    end

    task automatic compare_value(string what, logic [xlen-1:0] actual,
                                 logic [xlen-1:0] expected);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("[ERROR] %0t: %s is %h, expected %h", $time, what, actual, expected);
        end
    endtask

    function automatic logic [xlen-1:0] routing_bits(ex_result_t r);
        return {r.rd, r.csr_addr, r.mem_op, r.mem_rd, r.mem_wr,
                r.reg_wr, r.csr, r.ecall, r.mret};
    endfunction

    task automatic check_outputs();
        ex_result_t s1_res;
        s1_res = model_execute(m_s1);
        compare_value("out_valid", out_valid, m_s2_valid);
        if (out_valid && took_beat) begin
            delivered++;
        end
        if (m_s2_valid) begin
            compare_value("out.result", out.result, m_s2.result);
            compare_value("out.next_pc", out.next_pc, m_s2.next_pc);
            compare_value("out.redirect", out.redirect, m_s2.redirect);
            compare_value("out.store_data", out.store_data, m_s2.store_data);
            compare_value("out routing fields", routing_bits(out), routing_bits(m_s2));
        end
        compare_value("redirect_valid", redirect_valid, m_s1_valid && s1_res.redirect);
        if (m_s1_valid) begin
            compare_value("redirect_pc", redirect_pc, s1_res.next_pc);
        end
    endtask

    // ####################
    // stimulus
    // ####################

    task automatic drive_random();
        int        br_pick;
        ex_issue_t s;
        s.src1     = {$urandom, $urandom};
        s.src2     = ($urandom_range(0, 3) == 0) ? s.src1 : {$urandom, $urandom};
        s.imm      = $urandom;
        s.csr_data = {$urandom, $urandom};
        s.pc       = {$urandom, $urandom};
        s.csr_addr = $urandom;
        s.rd       = $urandom;
        s.alu_op   = alu_op_t'($urandom_range(0, 15));
        s.src_a    = src_a_t'($urandom_range(0, 1));
        s.src_b    = src_b_t'($urandom_range(0, 3));
        s.mem_op   = $urandom;
        {s.mem_rd, s.mem_wr, s.reg_wr, s.ecall, s.mret} = $urandom;
        s.csr      = ($urandom_range(0, 9) == 0);
        br_pick    = $urandom_range(0, 9);
        s.branch   = (br_pick <= 6) ? branch_t'(br_pick) : br_none;
        // pair the alu op with the branch the way decode does.
        case (s.branch)
            br_jal, br_jalr: begin
                s.alu_op = alu_add;
                s.src_a  = src_a_pc;
                s.src_b  = src_b_four;
            end
            br_eq, br_ne: begin
                s.alu_op = alu_sub;
                s.src_a  = src_a_rs1;
                s.src_b  = src_b_rs2;
            end
            br_lt, br_ge: begin
                s.alu_op = ($urandom_range(0, 1) == 0) ? alu_slt : alu_sltu;
                s.src_a  = src_a_rs1;
                s.src_b  = src_b_rs2;
            end
            default: ;
        endcase
        // the branch type stays random so a csr op must override it.
        if (s.csr) begin
            s.alu_op = alu_pass_b;
            s.src_b  = src_b_csr;
        end
        issue       = s;
        issue_valid = ($urandom_range(0, 9) < 8);
        block       = ($urandom_range(0, 9) < 2);
    endtask

    initial begin
        void'($urandom(32'he849));
        errors      = 0;
        checks      = 0;
        cycles      = 0;
        issued      = 0;
        delivered   = 0;
        took_beat   = 1'b0;
        clk         = 1'b0;
        reset       = 1'b1;
        block       = 1'b0;
        issue_valid = 1'b0;
        issue       = '0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        for (int i = 0; i < n_cycles; i++) begin
            @(negedge clk);
            check_outputs();
            drive_random();
        end
        issue_valid = 1'b0;
        block       = 1'b0;
        repeat (4) begin
            @(negedge clk);
            check_outputs();
        end
        compare_value("beats delivered", delivered, issued);
        $display("checks: %0d  errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

/* logic/ex_top.sv */
`timescale 1ns/1ps

module ex_top (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    block,
    input  logic                    issue_valid,
    input  ex_pkg::ex_issue_t       issue,
    output logic                    out_valid,
    output ex_pkg::ex_result_t      out,
    output logic                    redirect_valid,
    output logic [ex_pkg::xlen-1:0] redirect_pc
);

    import ex_pkg::*;

    logic       ex_valid;
    ex_issue_t  ex_bundle;
    ex_result_t result;

    // ####################
    // issue stage
    // ####################

    ex_pipe_reg #(
        .payload_t (ex_issue_t)
    ) issue_reg (
        .clk       (clk),
        .reset     (reset),
        .block     (block),
        .in_valid  (issue_valid),
        .in_data   (issue),
        .out_valid (ex_valid),
        .out_data  (ex_bundle)
    );

    // redirect leaves combinationally so fetch turns around this cycle.
    ex_stage exec (
        .clk            (clk),
        .reset          (reset),
        .ex_valid       (ex_valid),
        .ex_bundle      (ex_bundle),
        .result         (result),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc)
    );

    // ####################
    // result stage
    // ####################

    ex_pipe_reg #(
        .payload_t (ex_result_t)
    ) result_reg (
        .clk       (clk),
        .reset     (reset),
        .block     (block),
        .in_valid  (ex_valid),
        .in_data   (result),
        .out_valid (out_valid),
        .out_data  (out)
    );

endmodule

/* ex/ex_stage.sv */
`timescale 1ns/1ps

module ex_stage (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     ex_valid,
    input  ex_pkg::ex_issue_t        ex_bundle,
    output ex_pkg::ex_result_t       result,
    output logic                     redirect_valid,
    output logic [ex_pkg::xlen-1:0]  redirect_pc
);

    import ex_pkg::*;

    logic [xlen-1:0] imm_ext;
    logic [xlen-1:0] op_a;
    logic [xlen-1:0] op_b;
    logic [xlen-1:0] alu_y;
    logic            alu_zero;
    logic [xlen-1:0] next_pc;
    logic            jump;
    branch_t         branch_sel;

    // ####################
    // operand select
    // ####################

    assign imm_ext = {{(xlen - imm_w){ex_bundle.imm[imm_w-1]}}, ex_bundle.imm};

    assign op_a = (ex_bundle.src_a == src_a_pc) ? ex_bundle.pc : ex_bundle.src1;

    always_comb begin
        case (ex_bundle.src_b)
            src_b_rs2:  op_b = ex_bundle.src2;
            src_b_four: op_b = xlen'(4);
            src_b_imm:  op_b = imm_ext;
            default:    op_b = ex_bundle.csr_data;
        endcase
    end

    ex_alu alu (
        .op   (ex_bundle.alu_op),
        .a    (op_a),
        .b    (op_b),
        .y    (alu_y),
        .zero (alu_zero)
    );

    // ####################
    // next pc
    // ####################

    // csr ops flush the front end and resume at pc + 4.
    assign branch_sel = ex_bundle.csr ? br_none : ex_bundle.branch;

    ex_next_pc npc (
        .branch  (branch_sel),
        .pc      (ex_bundle.pc),
        .rs1     (ex_bundle.src1),
        .imm     (imm_ext),
        .zero    (alu_zero),
        .lt      (alu_y[0]),
        .next_pc (next_pc),
        .jump    (jump)
    );

    assign redirect_valid = ex_valid && (jump || ex_bundle.csr);
    assign redirect_pc    = next_pc;

    // ####################
    // result bundle
    // ####################

    always_comb begin
        result.result     = alu_y;
        result.store_data = ex_bundle.src2;
        result.next_pc    = next_pc;
        result.redirect   = redirect_valid;
        result.rd         = ex_bundle.rd;
        result.csr_addr   = ex_bundle.csr_addr;
        result.mem_op     = ex_bundle.mem_op;
        result.mem_rd     = ex_bundle.mem_rd;
        result.mem_wr     = ex_bundle.mem_wr;
        result.reg_wr     = ex_bundle.reg_wr;
        result.csr        = ex_bundle.csr;
        result.ecall      = ex_bundle.ecall;
        result.mret       = ex_bundle.mret;
    end

    alu_op_legal_a : assert property (
        @(posedge clk) disable iff (reset)
        ex_valid |-> (ex_bundle.alu_op <= alu_pass_b)
    ) else $error("illegal alu op issued from decode");

endmodule

/* ex/ex_next_pc.sv */
`timescale 1ns/1ps

module ex_next_pc (
    input  ex_pkg::branch_t         branch,
    input  logic [ex_pkg::xlen-1:0] pc,
    input  logic [ex_pkg::xlen-1:0] rs1,
    input  logic [ex_pkg::xlen-1:0] imm,
    input  logic                    zero,
    input  logic                    lt,
    output logic [ex_pkg::xlen-1:0] next_pc,
    output logic                    jump
);

    import ex_pkg::*;

    logic            taken;
    logic [xlen-1:0] pc_rel;
    logic [xlen-1:0] reg_rel;
    logic [xlen-1:0] seq_pc;

    // ####################
    // taken condition
    // ####################

    // eq/ne look at the sub result, lt/ge at the slt bit.
    always_comb begin
        case (branch)
            br_jal:  taken = 1'b1;
            br_jalr: taken = 1'b1;
            br_eq:   taken = zero;
            br_ne:   taken = !zero;
            br_lt:   taken = lt;
            br_ge:   taken = !lt;
            default: taken = 1'b0;
        endcase
    end

    // ####################
    // target
    // ####################

    assign pc_rel  = pc + imm;
    assign reg_rel = (rs1 + imm) & ~xlen'(1);
    assign seq_pc  = pc + xlen'(4);

    always_comb begin
        if (!taken) begin
            next_pc = seq_pc;
        end else if (branch == br_jalr) begin
            next_pc = reg_rel;
        end else begin
            next_pc = pc_rel;
        end
    end

    assign jump = taken;

endmodule

/* ex/ex_alu.sv */
`timescale 1ns/1ps

module ex_alu (
    input  ex_pkg::alu_op_t         op,
    input  logic [ex_pkg::xlen-1:0] a,
    input  logic [ex_pkg::xlen-1:0] b,
    output logic [ex_pkg::xlen-1:0] y,
    output logic                    zero
);

    import ex_pkg::*;

    localparam int word_w = 32;

    logic [5:0]        shamt;
    logic [4:0]        shamt_w;
    logic [word_w-1:0] a_w;
    logic [word_w-1:0] b_w;
    logic [word_w-1:0] y_w;
    logic              is_word;
    logic [xlen-1:0]   y_full;

    assign shamt   = b[5:0];
    assign shamt_w = b[4:0];
    assign a_w     = a[word_w-1:0];
    assign b_w     = b[word_w-1:0];

    // ####################
    // full width
    // ####################

    always_comb begin
        case (op)
            alu_add:    y_full = a + b;
            alu_sub:    y_full = a - b;
            alu_sll:    y_full = a << shamt;
            alu_slt:    y_full = {{(xlen - 1){1'b0}}, $signed(a) < $signed(b)};
            alu_sltu:   y_full = {{(xlen - 1){1'b0}}, a < b};
            alu_xor:    y_full = a ^ b;
            alu_srl:    y_full = a >> shamt;
            alu_sra:    y_full = $unsigned($signed(a) >>> shamt);
            alu_or:     y_full = a | b;
            alu_and:    y_full = a & b;
            alu_pass_b: y_full = b;
            default:    y_full = '0;
        endcase
    end

    // ####################
    // rv64 word ops
    // ####################

    always_comb begin
        is_word = 1'b1;
        case (op)
            alu_addw: y_w = a_w + b_w;
            alu_subw: y_w = a_w - b_w;
            alu_sllw: y_w = a_w << shamt_w;
            alu_srlw: y_w = a_w >> shamt_w;
            alu_sraw: y_w = $unsigned($signed(a_w) >>> shamt_w);
            default: begin
                y_w     = '0;
                is_word = 1'b0;
            end
        endcase
    end

    // word results are sign-extended from bit 31.
    assign y = is_word ? {{(xlen - word_w){y_w[word_w-1]}}, y_w} : y_full;

    assign zero = (y == '0);

endmodule

/* logic/ex_pipe_reg.sv */
`timescale 1ns/1ps

module ex_pipe_reg #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     reset,
    input  logic     block,
    input  logic     in_valid,
    input  payload_t in_data,
    output logic     out_valid,
    output payload_t out_data
);

    // ####################
    // stage registers
    // ####################

    // block freezes the stage, otherwise a new beat is taken each edge.
    always_ff @(posedge clk) begin
        if (reset) begin
            out_valid <= 1'b0;
        end else if (!block) begin
            out_valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (!block) begin
            out_data <= in_data;
        end
    end

    // ####################
    // checks
    // ####################

    valid_known_a : assert property (
        @(posedge clk) disable iff (reset)
        !$isunknown(out_valid)
    ) else $error("pipe register valid is unknown");

    // a held beat must not change under the stall.
    hold_stable_a : assert property (
        @(posedge clk) disable iff (reset)
        (block && out_valid) |=> ($stable(out_data) && out_valid)
    ) else $error("pipe register payload changed while blocked");

endmodule

/* common/ex_pkg.sv */
package ex_pkg;

    // ####################
    // widths
    // ####################

    localparam int xlen       = 64;
    localparam int imm_w      = 32;
    localparam int reg_addr_w = 5;
    localparam int csr_addr_w = 12;

    // ####################
    // control codes
    // ####################

    // codes above alu_pass_b are illegal.
    typedef enum logic [4:0] {
        alu_add    = 5'd0,
        alu_sub    = 5'd1,
        alu_sll    = 5'd2,
        alu_slt    = 5'd3,
        alu_sltu   = 5'd4,
        alu_xor    = 5'd5,
        alu_srl    = 5'd6,
        alu_sra    = 5'd7,
        alu_or     = 5'd8,
        alu_and    = 5'd9,
        alu_addw   = 5'd10,
        alu_subw   = 5'd11,
        alu_sllw   = 5'd12,
        alu_srlw   = 5'd13,
        alu_sraw   = 5'd14,
        alu_pass_b = 5'd15
    } alu_op_t;

    typedef enum logic [2:0] {
        br_none = 3'd0,
        br_jal  = 3'd1,
        br_jalr = 3'd2,
        br_eq   = 3'd3,
        br_ne   = 3'd4,
        br_lt   = 3'd5,
        br_ge   = 3'd6
    } branch_t;

    typedef enum logic {
        src_a_rs1 = 1'b0,
        src_a_pc  = 1'b1
    } src_a_t;

    typedef enum logic [1:0] {
        src_b_rs2  = 2'd0,
        src_b_four = 2'd1,
        src_b_imm  = 2'd2,
        src_b_csr  = 2'd3
    } src_b_t;

    // size and sign of the load or store, not decoded here.
    typedef logic [2:0] mem_op_t;

    // ####################
    // bundles
    // ####################

    typedef struct packed {
        logic [xlen-1:0]       src1;
        logic [xlen-1:0]       src2;
        logic [imm_w-1:0]      imm;
        logic [xlen-1:0]       csr_data;
        logic [xlen-1:0]       pc;
        logic [csr_addr_w-1:0] csr_addr;
        logic [reg_addr_w-1:0] rd;
        alu_op_t               alu_op;
        src_a_t                src_a;
        src_b_t                src_b;
        branch_t               branch;
        mem_op_t               mem_op;
        logic                  mem_rd;
        logic                  mem_wr;
        logic                  reg_wr;
        logic                  csr;
        logic                  ecall;
        logic                  mret;
    } ex_issue_t;

    typedef struct packed {
        logic [xlen-1:0]       result;
        logic [xlen-1:0]       store_data;
        logic [xlen-1:0]       next_pc;
        logic                  redirect;
        logic [reg_addr_w-1:0] rd;
        logic [csr_addr_w-1:0] csr_addr;
        mem_op_t               mem_op;
        logic                  mem_rd;
        logic                  mem_wr;
        logic                  reg_wr;
        logic                  csr;
        logic                  ecall;
        logic                  mret;
    } ex_result_t;

endpackage
